//--- compile.f
+incdir+rtl
rtl/cavlc_types_pkg.sv
rtl/cavlc_ctrl_pkg.sv
rtl/cavlc_block_if.sv
rtl/cavlc_enc_ctrl.sv
rtl/coeff_token_enc.sv
rtl/level_code_enc.sv
rtl/cavlc_enc_top.sv
tb/cavlc_enc_sva.sv
tb/cavlc_enc_tb.sv

//--- Bender.yml
package:
  name: cavlc_enc

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cavlc_types_pkg.sv
      - rtl/cavlc_ctrl_pkg.sv
      - rtl/cavlc_block_if.sv
      - rtl/cavlc_enc_ctrl.sv
      - rtl/coeff_token_enc.sv
      - rtl/level_code_enc.sv
      - rtl/cavlc_enc_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/cavlc_enc_sva.sv
      - tb/cavlc_enc_tb.sv

//--- tb/cavlc_enc_tb.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

module cavlc_enc_tb;
    import cavlc_types_pkg::*;

    localparam int TIMEOUT = 100;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic                          bis_ready;
    logic [`CAVLC_T1_CNT_W-1:0]    t1_cnt;
    logic [`CAVLC_T1_FLAG_W-1:0]   t1_flags;
    logic [`CAVLC_CNT_W-1:0]       total_coeff;
    logic [`CAVLC_CNT_W-1:0]       level_cnt;
    level_code_t                   levels [`CAVLC_MAX_COEFF];
    logic                          in_ready;
    logic                          out_valid;
    token_code_t                   coeff_token_code;
    code_len_t                     coeff_token_len;
    logic [`CAVLC_T1_FLAG_W-1:0]   t1_code;
    logic [`CAVLC_T1_CNT_W-1:0]    t1_len;
    logic                          level_valid;
    level_word_t                   level_code;
    code_len_t                     level_len;

    level_code_t next_levels [`CAVLC_MAX_COEFF]; // Levels of the block about to be sent
    int          value_errors = 0;
    int          other_errors = 0;
    integer      seed = 32'he7e9_fd34;

    cavlc_enc_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_token(input token_code_t got_code, input token_code_t exp_code,
                                 input code_len_t got_len, input code_len_t exp_len);
        if (got_code !== exp_code) begin
            $display("FAIL coeff_token_code got %h expected %h", got_code, exp_code);
            value_errors++;
        end
        if (got_len !== exp_len) begin
            $display("FAIL coeff_token_len got %h expected %h", got_len, exp_len);
            value_errors++;
        end
    endtask

    task automatic compare_level(input level_word_t got_code, input level_word_t exp_code,
                                 input code_len_t got_len, input code_len_t exp_len);
        if (got_code !== exp_code || got_len !== exp_len) begin
            $display("FAIL level_code/level_len got %h/%h expected %h/%h",
                     got_code, got_len, exp_code, exp_len);
            value_errors++;
        end
    endtask

    task automatic compare_t1(input logic [2:0] got_code, input logic [2:0] exp_code,
                              input logic [1:0] got_len, input logic [1:0] exp_len);
        if (got_code !== exp_code || got_len !== exp_len) begin
            $display("FAIL t1_code/t1_len got %h/%h expected %h/%h",
                     got_code, got_len, exp_code, exp_len);
            value_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Codeword length in the top bits, right-aligned codeword below
    function automatic logic [32:0] level_model(input int c, input int s);
        int prefix;
        int size;
        int suffix;
        prefix = 15;
        size   = 12;
        suffix = c - ((s == 0) ? 30 : (15 << s));
        if (s == 0 && c < 14) begin
            prefix = c;
            size   = 0;
            suffix = 0;
        end else if (s == 0 && c < 30) begin
            prefix = 14;
            size   = 4;
            suffix = c - 14;
        end else if (s > 0 && c < (15 << s)) begin
            prefix = c >> s;
            size   = s;
            suffix = c % (1 << s);
        end
        return {code_len_t'(prefix + 1 + size), level_word_t'((1 << size) + suffix)};
    endfunction

    function automatic int next_suffix(input int c, input int s);
        int s_new;
        s_new = (s == 0) ? 1 : s;
        if ((c >> 1) + 1 > 3 * (1 << (s_new - 1)) && s_new < `CAVLC_SUFFIX_MAX) begin
            s_new++;
        end
        return s_new;
    endfunction

    task automatic wait_in_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge clk);
            ok = in_ready;
        end
        if (!ok) begin
            $display("ERROR: timed out waiting for in_ready");
            other_errors++;
        end
    endtask

    // Sends one block, checks every level pulse and the held fields, then releases it
    task automatic run_block(input logic [1:0] t1, input logic [2:0] flags,
                             input logic [4:0] tc, input logic [4:0] lc, input int hold,
                             input bit chk_tok, input token_code_t exp_code,
                             input code_len_t exp_len);
        bit          ok;
        int          s;
        int          idx;
        int          n;
        logic [32:0] exp;
        wait_in_ready(ok);
        if (!ok) begin
            return;
        end
        @(posedge clk);
        in_valid    <= 1'b1;
        t1_cnt      <= t1;
        t1_flags    <= flags;
        total_coeff <= tc;
        level_cnt   <= lc;
        for (int i = 0; i < `CAVLC_MAX_COEFF; i++) begin
            levels[i] <= next_levels[i];
        end
        @(posedge clk); // in_ready is still high, so this edge takes the block
        in_valid <= 1'b0;
        s   = (tc > 10 && t1 < 3) ? 1 : 0;
        idx = 0;
        n   = 0;
        do begin
            @(negedge clk);
            n++;
            if (level_valid) begin
                if (idx < lc) begin
                    exp = level_model(next_levels[idx], s);
                    compare_level(level_code, exp[`CAVLC_LEVEL_CODE_W-1:0], level_len,
                                  exp[32:`CAVLC_LEVEL_CODE_W]);
                    s = next_suffix(next_levels[idx], s);
                end
                idx++;
            end
        end while (!out_valid && n < TIMEOUT);
        if (!out_valid) begin
            $display("ERROR: timed out waiting for out_valid");
            other_errors++;
            return;
        end
        if (n != 18) begin
            $display("ERROR: out_valid came %0d cycles after acceptance instead of 18", n);
            other_errors++;
        end
        if (idx != lc) begin
            $display("FAIL level_valid pulses got %h expected %h", idx, lc);
            value_errors++;
        end
        if (chk_tok) begin
            compare_token(coeff_token_code, exp_code, coeff_token_len, exp_len);
        end
        compare_t1(t1_code, flags, t1_len, t1);
        exp_code = coeff_token_code;
        exp_len  = coeff_token_len;
        repeat (hold) begin
            @(negedge clk);
            compare_token(coeff_token_code, exp_code, coeff_token_len, exp_len);
            compare_t1(t1_code, flags, t1_len, t1);
            compare_bit("out_valid", out_valid, 1'b1);
            compare_bit("in_ready", in_ready, 1'b0);
        end
        @(posedge clk);
        bis_ready <= 1'b1;
        @(posedge clk);
        bis_ready <= 1'b0;
        @(negedge clk);
        compare_bit("in_ready", in_ready, 1'b1);
    endtask

    task automatic fill_random_levels();
        for (int i = 0; i < `CAVLC_MAX_COEFF; i++) begin
            // Odd slots stay small, even slots often need the escape code
            next_levels[i] = (i % 2) ? level_code_t'($random(seed) & 31)
                                     : level_code_t'($random(seed));
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare_bit("in_ready", in_ready, 1'b1);
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("level_valid", level_valid, 1'b0);
    endtask

    task automatic test_token_table();
        run_block(2'd0, 3'd0, 5'd0, 5'd0, 0, 1'b1, 16'h0001, 5'd1);
        run_block(2'd1, 3'd1, 5'd1, 5'd0, 0, 1'b1, 16'h0001, 5'd2);
        run_block(2'd0, 3'd0, 5'd1, 5'd0, 0, 1'b1, 16'h0005, 5'd6);
        run_block(2'd2, 3'd2, 5'd2, 5'd0, 0, 1'b1, 16'h0001, 5'd3);
        run_block(2'd1, 3'd0, 5'd2, 5'd0, 0, 1'b1, 16'h0004, 5'd6);
        run_block(2'd3, 3'd5, 5'd3, 5'd0, 0, 1'b1, 16'h0003, 5'd5);
    endtask

    task automatic test_level_sequence();
        logic [1:0] t1;
        for (int lc = 0; lc <= `CAVLC_MAX_COEFF; lc++) begin
            fill_random_levels();
            t1 = 2'($random(seed));
            run_block(t1, 3'($random(seed)), 5'(lc), 5'(lc), 0, 1'b0, '0, '0);
        end
    endtask

    task automatic test_suffix_adapt();
        // Doubling levels push suffixLength from 1 up to 6, then 255 stays there
        for (int i = 0; i < `CAVLC_MAX_COEFF; i++) begin
            next_levels[i] = (i < 6) ? level_code_t'(4 << i) : 8'd255;
        end
        run_block(2'd0, 3'd0, 5'd16, 5'd16, 0, 1'b0, '0, '0);
    endtask

    task automatic test_back_pressure();
        int hold;
        hold = 3 + ($unsigned($random(seed)) % 16);
        fill_random_levels();
        run_block(2'd1, 3'd1, 5'd9, 5'd8, hold, 1'b0, '0, '0);
        fill_random_levels();
        run_block(2'd0, 3'd0, 5'd12, 5'd12, 0, 1'b0, '0, '0);
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        bis_ready   = 1'b0;
        t1_cnt      = '0;
        t1_flags    = '0;
        total_coeff = '0;
        level_cnt   = '0;
        for (int i = 0; i < `CAVLC_MAX_COEFF; i++) begin
            levels[i]      = '0;
            next_levels[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_token_table();
        test_level_sequence();
        test_suffix_adapt();
        test_back_pressure();
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, uut.u_sva.fail_cnt);
        if (value_errors + other_errors + uut.u_sva.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : cavlc_enc_tb

//--- tb/cavlc_enc_sva.sv
`timescale 1ns/1ps

module cavlc_enc_sva (
    input logic                          clk,
    input logic                          rst,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic                          out_valid,
    input logic                          bis_ready,
    input cavlc_types_pkg::token_code_t  coeff_token_code,
    input cavlc_types_pkg::code_len_t    coeff_token_len,
    input logic [2:0]                    t1_code,
    input logic [1:0]                    t1_len
);
    int fail_cnt = 0;

    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        !(in_ready && out_valid))
        else begin
            $error("in_ready overlaps out_valid");
            fail_cnt++;
        end

    a_hold_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid && !bis_ready |=> out_valid)
        else begin
            $error("out_valid dropped before bis_ready");
            fail_cnt++;
        end

    a_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !bis_ready |=> $stable(coeff_token_code) && $stable(coeff_token_len)
                                    && $stable(t1_code) && $stable(t1_len))
        else begin
            $error("Outputs changed while stalled in WAITBIS");
            fail_cnt++;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |-> ##18 $rose(out_valid))
        else begin
            $error("out_valid did not rise 18 cycles after acceptance");
            fail_cnt++;
        end

endmodule : cavlc_enc_sva

bind cavlc_enc_top cavlc_enc_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .out_valid        (out_valid),
    .bis_ready        (bis_ready),
    .coeff_token_code (coeff_token_code),
    .coeff_token_len  (coeff_token_len),
    .t1_code          (t1_code),
    .t1_len           (t1_len)
);

//--- rtl/cavlc_enc_top.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

module cavlc_enc_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [`CAVLC_T1_CNT_W-1:0]    t1_cnt,
    input  logic [`CAVLC_T1_FLAG_W-1:0]   t1_flags,
    input  logic [`CAVLC_CNT_W-1:0]       total_coeff,
    input  logic [`CAVLC_CNT_W-1:0]       level_cnt,
    input  cavlc_types_pkg::level_code_t  levels [`CAVLC_MAX_COEFF],
    input  logic                          bis_ready,
    output logic                          in_ready,
    output logic                          out_valid,
    output cavlc_types_pkg::token_code_t  coeff_token_code,
    output cavlc_types_pkg::code_len_t    coeff_token_len,
    output logic [`CAVLC_T1_FLAG_W-1:0]   t1_code,
    output logic [`CAVLC_T1_CNT_W-1:0]    t1_len,
    output logic                          level_valid,
    output cavlc_types_pkg::level_word_t  level_code,
    output cavlc_types_pkg::code_len_t    level_len
);
    import cavlc_types_pkg::*;

    blk_stats_t in_stats;

    cavlc_block_if blk_if ();

    always_comb begin
        in_stats.t1_cnt      = t1_cnt;
        in_stats.t1_flags    = t1_flags;
        in_stats.total_coeff = total_coeff;
        in_stats.level_cnt   = level_cnt;
        for (int i = 0; i < `CAVLC_MAX_COEFF; i++) begin
            in_stats.levels[i] = levels[i];
        end
    end

    // Trailing-ones signs go out unchanged, one bit per trailing one
    assign t1_code = blk_if.stats.t1_flags;
    assign t1_len  = blk_if.stats.t1_cnt;

    cavlc_enc_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_stats  (in_stats),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .bis_ready (bis_ready),
        .blk       (blk_if)
    );

    coeff_token_enc u_token (
        .clk        (clk),
        .rst        (rst),
        .blk        (blk_if),
        .token_code (coeff_token_code),
        .token_len  (coeff_token_len)
    );

    level_code_enc u_level (
        .clk         (clk),
        .rst         (rst),
        .blk         (blk_if),
        .level_valid (level_valid),
        .level_code  (level_code),
        .level_len   (level_len)
    );

endmodule : cavlc_enc_top

//--- rtl/level_code_enc.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

module level_code_enc (
    input  logic                       clk,
    input  logic                       rst,
    cavlc_block_if.enc                 blk,
    output logic                       level_valid,
    output cavlc_types_pkg::level_word_t level_code,
    output cavlc_types_pkg::code_len_t   level_len
);
    import cavlc_types_pkg::*;

    level_code_t                    c;
    logic [`CAVLC_SUFFIX_LEN_W-1:0] s_len;
    logic [`CAVLC_SUFFIX_LEN_W-1:0] s_base;
    logic [`CAVLC_SUFFIX_LEN_W-1:0] s_next;
    logic [9:0]                     esc_base;
    logic [4:0]                     prefix;
    logic [`CAVLC_ESC_SUFFIX_W-1:0] suffix;
    logic [3:0]                     suf_size;
    logic [7:0]                     abs_lvl;
    logic [7:0]                     thresh;
    logic                           encode;
    level_word_t                    code_next;
    code_len_t                      len_next;

    assign c        = blk.stats.levels[blk.enc_idx];
    assign encode   = blk.enc_active && ({1'b0, blk.enc_idx} < blk.stats.level_cnt);
    assign esc_base = 10'd15 << s_len; // First levelCode that needs the escape prefix

    always_comb begin
        prefix   = 5'(`CAVLC_ESC_PREFIX);
        suffix   = `CAVLC_ESC_SUFFIX_W'({2'b00, c} - esc_base);
        suf_size = 4'(`CAVLC_ESC_SUFFIX_W);
        if (s_len == '0) begin
            if (c < 8'd14) begin
                prefix   = c[4:0];
                suffix   = '0;
                suf_size = 4'd0;
            end else if (c < 8'd30) begin
                prefix   = 5'd14;
                suffix   = `CAVLC_ESC_SUFFIX_W'(c - 8'd14);
                suf_size = 4'd4;
            end else begin
                suffix   = `CAVLC_ESC_SUFFIX_W'(c - 8'd30);
            end
        end else if ({2'b00, c} < esc_base) begin
            prefix   = 5'(c >> s_len);
            suffix   = `CAVLC_ESC_SUFFIX_W'(c & ~(8'hff << s_len));
            suf_size = 4'(s_len);
        end
        code_next = level_word_t'(suffix) | (level_word_t'(1) << suf_size);
        len_next  = code_len_t'(prefix) + code_len_t'(1) + code_len_t'(suf_size);
    end

    // suffixLength adaptation after each coded level
    always_comb begin
        s_base  = (s_len == '0) ? `CAVLC_SUFFIX_LEN_W'(1) : s_len;
        abs_lvl = {1'b0, c[7:1]} + 8'd1;
        thresh  = 8'd3 << (s_base - 1'b1);
        s_next  = s_base;
        if ((abs_lvl > thresh) && (s_base < `CAVLC_SUFFIX_LEN_W'(`CAVLC_SUFFIX_MAX))) begin
            s_next = s_base + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_len       <= '0;
            level_valid <= 1'b0;
        end else begin
            level_valid <= encode;
            if (blk.load) begin
                s_len <= ((blk.stats.total_coeff > 5'd10) && (blk.stats.t1_cnt < 2'd3)) ?
                         `CAVLC_SUFFIX_LEN_W'(1) : '0;
            end else if (encode) begin
                s_len <= s_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (encode) begin
            level_code <= code_next;
            level_len  <= len_next;
        end
    end

endmodule : level_code_enc

//--- rtl/coeff_token_enc.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

module coeff_token_enc (
    input  logic                       clk,
    input  logic                       rst,
    cavlc_block_if.enc                 blk,
    output cavlc_types_pkg::token_code_t token_code,
    output cavlc_types_pkg::code_len_t   token_len
);
    import cavlc_types_pkg::*;

    token_code_t lut_code;
    code_len_t   lut_len;

    // coeff_token table for 0 <= nC < 2, keyed by {TrailingOnes, TotalCoeff}
    always_comb begin
        {lut_code, lut_len} = '0; // Impossible combinations give length 0
        case ({blk.stats.t1_cnt, blk.stats.total_coeff})
            {2'd0, 5'd0}:  {lut_code, lut_len} = {16'd1, 5'd1};
            {2'd0, 5'd1}:  {lut_code, lut_len} = {16'd5, 5'd6};
            {2'd0, 5'd2}:  {lut_code, lut_len} = {16'd7, 5'd8};
            {2'd0, 5'd3}:  {lut_code, lut_len} = {16'd7, 5'd9};
            {2'd0, 5'd4}:  {lut_code, lut_len} = {16'd7, 5'd10};
            {2'd0, 5'd5}:  {lut_code, lut_len} = {16'd7, 5'd11};
            {2'd0, 5'd6}:  {lut_code, lut_len} = {16'd15, 5'd13};
            {2'd0, 5'd7}:  {lut_code, lut_len} = {16'd11, 5'd13};
            {2'd0, 5'd8}:  {lut_code, lut_len} = {16'd8, 5'd13};
            {2'd0, 5'd9}:  {lut_code, lut_len} = {16'd15, 5'd14};
            {2'd0, 5'd10}: {lut_code, lut_len} = {16'd11, 5'd14};
            {2'd0, 5'd11}: {lut_code, lut_len} = {16'd15, 5'd15};
            {2'd0, 5'd12}: {lut_code, lut_len} = {16'd11, 5'd15};
            {2'd0, 5'd13}: {lut_code, lut_len} = {16'd15, 5'd16};
            {2'd0, 5'd14}: {lut_code, lut_len} = {16'd11, 5'd16};
            {2'd0, 5'd15}: {lut_code, lut_len} = {16'd7, 5'd16};
            {2'd0, 5'd16}: {lut_code, lut_len} = {16'd4, 5'd16};
            {2'd1, 5'd1}:  {lut_code, lut_len} = {16'd1, 5'd2};
            {2'd1, 5'd2}:  {lut_code, lut_len} = {16'd4, 5'd6};
            {2'd1, 5'd3}:  {lut_code, lut_len} = {16'd6, 5'd8};
            {2'd1, 5'd4}:  {lut_code, lut_len} = {16'd6, 5'd9};
            {2'd1, 5'd5}:  {lut_code, lut_len} = {16'd6, 5'd10};
            {2'd1, 5'd6}:  {lut_code, lut_len} = {16'd6, 5'd11};
            {2'd1, 5'd7}:  {lut_code, lut_len} = {16'd14, 5'd13};
            {2'd1, 5'd8}:  {lut_code, lut_len} = {16'd10, 5'd13};
            {2'd1, 5'd9}:  {lut_code, lut_len} = {16'd14, 5'd14};
            {2'd1, 5'd10}: {lut_code, lut_len} = {16'd10, 5'd14};
            {2'd1, 5'd11}: {lut_code, lut_len} = {16'd14, 5'd15};
            {2'd1, 5'd12}: {lut_code, lut_len} = {16'd10, 5'd15};
            {2'd1, 5'd13}: {lut_code, lut_len} = {16'd1, 5'd15};
            {2'd1, 5'd14}: {lut_code, lut_len} = {16'd14, 5'd16};
            {2'd1, 5'd15}: {lut_code, lut_len} = {16'd10, 5'd16};
            {2'd1, 5'd16}: {lut_code, lut_len} = {16'd6, 5'd16};
            {2'd2, 5'd2}:  {lut_code, lut_len} = {16'd1, 5'd3};
            {2'd2, 5'd3}:  {lut_code, lut_len} = {16'd5, 5'd7};
            {2'd2, 5'd4}:  {lut_code, lut_len} = {16'd5, 5'd8};
            {2'd2, 5'd5}:  {lut_code, lut_len} = {16'd5, 5'd9};
            {2'd2, 5'd6}:  {lut_code, lut_len} = {16'd5, 5'd10};
            {2'd2, 5'd7}:  {lut_code, lut_len} = {16'd5, 5'd11};
            {2'd2, 5'd8}:  {lut_code, lut_len} = {16'd13, 5'd13};
            {2'd2, 5'd9}:  {lut_code, lut_len} = {16'd9, 5'd13};
            {2'd2, 5'd10}: {lut_code, lut_len} = {16'd13, 5'd14};
            {2'd2, 5'd11}: {lut_code, lut_len} = {16'd9, 5'd14};
            {2'd2, 5'd12}: {lut_code, lut_len} = {16'd13, 5'd15};
            {2'd2, 5'd13}: {lut_code, lut_len} = {16'd9, 5'd15};
            {2'd2, 5'd14}: {lut_code, lut_len} = {16'd13, 5'd16};
            {2'd2, 5'd15}: {lut_code, lut_len} = {16'd9, 5'd16};
            {2'd2, 5'd16}: {lut_code, lut_len} = {16'd5, 5'd16};
            {2'd3, 5'd3}:  {lut_code, lut_len} = {16'd3, 5'd5};
            {2'd3, 5'd4}:  {lut_code, lut_len} = {16'd3, 5'd6};
            {2'd3, 5'd5}:  {lut_code, lut_len} = {16'd4, 5'd7};
            {2'd3, 5'd6}:  {lut_code, lut_len} = {16'd4, 5'd8};
            {2'd3, 5'd7}:  {lut_code, lut_len} = {16'd4, 5'd9};
            {2'd3, 5'd8}:  {lut_code, lut_len} = {16'd4, 5'd10};
            {2'd3, 5'd9}:  {lut_code, lut_len} = {16'd4, 5'd11};
            {2'd3, 5'd10}: {lut_code, lut_len} = {16'd12, 5'd13};
            {2'd3, 5'd11}: {lut_code, lut_len} = {16'd12, 5'd14};
            {2'd3, 5'd12}: {lut_code, lut_len} = {16'd8, 5'd14};
            {2'd3, 5'd13}: {lut_code, lut_len} = {16'd12, 5'd15};
            {2'd3, 5'd14}: {lut_code, lut_len} = {16'd8, 5'd15};
            {2'd3, 5'd15}: {lut_code, lut_len} = {16'd12, 5'd16};
            {2'd3, 5'd16}: {lut_code, lut_len} = {16'd8, 5'd16};
            default: {lut_code, lut_len} = '0;
        endcase
    end

    // Captured at the end of the window and held through WAITBIS
    always_ff @(posedge clk) begin
        if (rst) begin
            token_code <= '0;
            token_len  <= '0;
        end else if (blk.enc_done) begin
            token_code <= lut_code;
            token_len  <= lut_len;
        end
    end

endmodule : coeff_token_enc

//--- rtl/cavlc_enc_ctrl.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

module cavlc_enc_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  cavlc_types_pkg::blk_stats_t in_stats,
    output logic                      in_ready,
    output logic                      out_valid,
    input  logic                      bis_ready,
    cavlc_block_if.ctrl               blk
);
    import cavlc_types_pkg::*;
    import cavlc_ctrl_pkg::*;

    enc_state_t              state;
    enc_state_t              next_state;
    logic [`CAVLC_IDX_W-1:0] cycle;
    blk_stats_t              stats_q;
    logic                    accept;

    assign accept    = in_valid && in_ready;
    assign in_ready  = (state == IDLE);
    assign out_valid = (state == WAITBIS);

    // Block statistics are held for the whole encode and until release
    always_ff @(posedge clk) begin
        if (accept) begin
            stats_q <= in_stats;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                next_state = ENC;
            end
            ENC: begin
                if (cycle == `CAVLC_IDX_W'(`CAVLC_MAX_COEFF - 1)) begin
                    next_state = WAITBIS;
                end
            end
            WAITBIS: begin
                if (bis_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Wraps back to zero after the sixteenth ENC cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (state == ENC) begin
            cycle <= cycle + 1'b1;
        end else begin
            cycle <= '0;
        end
    end

    assign blk.stats      = stats_q;
    assign blk.load       = (state == LOAD);
    assign blk.enc_active = (state == ENC);
    assign blk.enc_idx    = cycle;
    assign blk.enc_done   = (state == ENC) && (next_state == WAITBIS);

endmodule : cavlc_enc_ctrl

//--- rtl/cavlc_block_if.sv
`timescale 1ns/1ps
`include "cavlc_consts.svh"

interface cavlc_block_if;
    import cavlc_types_pkg::*;

    blk_stats_t              stats;
    logic                    load;       // High for the single LOAD cycle
    logic                    enc_active; // High through the sixteen ENC cycles
    logic [`CAVLC_IDX_W-1:0] enc_idx;
    logic                    enc_done;   // Last ENC cycle, just before WAITBIS

    modport ctrl (
        output stats,
        output load,
        output enc_active,
        output enc_idx,
        output enc_done
    );

    modport enc (
        input stats,
        input load,
        input enc_active,
        input enc_idx,
        input enc_done
    );

endinterface : cavlc_block_if

//--- rtl/cavlc_ctrl_pkg.sv
package cavlc_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOAD    = 2'd1,
        ENC     = 2'd2,
        WAITBIS = 2'd3
    } enc_state_t;

endpackage : cavlc_ctrl_pkg

//--- rtl/cavlc_types_pkg.sv
`include "cavlc_consts.svh"

package cavlc_types_pkg;

    typedef logic [`CAVLC_LEVEL_IN_W-1:0] level_code_t;

    // Statistics of one 4x4 block as delivered by the scanner
    typedef struct packed {
        logic [`CAVLC_T1_CNT_W-1:0]                t1_cnt;
        logic [`CAVLC_T1_FLAG_W-1:0]               t1_flags;
        logic [`CAVLC_CNT_W-1:0]                   total_coeff;
        logic [`CAVLC_CNT_W-1:0]                   level_cnt;
        level_code_t [`CAVLC_MAX_COEFF-1:0]        levels;
    } blk_stats_t;

    typedef logic [`CAVLC_TOKEN_CODE_W-1:0] token_code_t; // Right-aligned codeword
    typedef logic [`CAVLC_LEVEL_CODE_W-1:0] level_word_t; // Right-aligned codeword
    typedef logic [`CAVLC_LEVEL_LEN_W-1:0]  code_len_t;

endpackage : cavlc_types_pkg

//--- rtl/cavlc_consts.svh
`ifndef CAVLC_CONSTS_SVH
`define CAVLC_CONSTS_SVH

`define CAVLC_MAX_COEFF      16 // Coefficients per 4x4 block and encode cycles
`define CAVLC_IDX_W          4
`define CAVLC_CNT_W          5  // Counts up to 16 inclusive
`define CAVLC_T1_CNT_W       2
`define CAVLC_T1_FLAG_W      3

`define CAVLC_LEVEL_IN_W     8
`define CAVLC_LEVEL_CODE_W   28 // 15 prefix zeros, stop bit, 12 suffix bits
`define CAVLC_LEVEL_LEN_W    5
`define CAVLC_TOKEN_CODE_W   16
`define CAVLC_TOKEN_LEN_W    5

`define CAVLC_SUFFIX_MAX     6
`define CAVLC_SUFFIX_LEN_W   3
`define CAVLC_ESC_PREFIX     15
`define CAVLC_ESC_SUFFIX_W   12

`endif
